// File: Makefile
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: common/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and address width
`define XLEN 32

// architectural registers, x0 included
`define NUM_REGS 32

`define RESET_PC 32'h0000_0000 // first fetch address

// a7 value that turns ecall into a halt
`define HALT_CODE 10

`endif

// File: common/isa_pkg.sv
`include "core_settings.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

  localparam reg_idx_t reg_a7 = reg_idx_t'(17); // ecall argument register

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_system = 7'b1110011
  } opcode_e;

  // funct3 of the reg-reg and reg-imm ALU group
  typedef enum logic [2:0] {
    f3_add_sub = 3'b000,
    f3_sll     = 3'b001,
    f3_slt     = 3'b010,
    f3_xor     = 3'b100,
    f3_srl_sra = 3'b101,  // instr[30] picks arithmetic
    f3_or      = 3'b110,
    f3_and     = 3'b111
  } alu_funct3_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sll, alu_srl, alu_sra, alu_pass_b
  } alu_op_e;

  // branch funct3
  typedef enum logic [2:0] {
    br_eq = 3'b000,
    br_ne = 3'b001,
    br_lt = 3'b100,
    br_ge = 3'b101
  } br_cond_e;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;
  import isa_pkg::*;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    alu_op_e  alu_op;
    logic     alu_src_imm; // operand b is the immediate
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    logic     link;        // rd gets pc+4
    logic     is_branch;
    logic     is_jal;
    logic     is_jalr;
    br_cond_e br_cond;
    logic     halt;        // ecall seen with a7 == halt code
  } ctrl_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    word_t    pc;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    logic     halt;
    word_t    alu_out;    // also the data address
    word_t    store_data;
    reg_idx_t rd;
    word_t    wb_value;   // pc+4 or alu result, already picked
  } ex_mem_t;

  typedef struct packed {
    logic  read;
    logic  write;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } commit_t;

  typedef enum logic [1:0] {
    fwd_none     = 2'd0,
    fwd_from_mem = 2'd1,
    fwd_from_wb  = 2'd2
  } fwd_sel_e;

  // operand source mux shared by decode and execute
  function automatic word_t fwd_mux(fwd_sel_e sel, word_t from_reg, word_t from_mem,
                                    word_t from_wb);
    case (sel)
      fwd_from_mem: return from_mem;
      fwd_from_wb:  return from_wb;
      default:      return from_reg;
    endcase
  endfunction

endpackage

// File: decode/decode_stage.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     flush,          // redirect from execute
  input  if_id_t   if_id,
  input  commit_t  wb,
  input  word_t    mem_fwd_value,  // EX/MEM result for the a7 check
  input  fwd_sel_e ecall_fwd,
  output reg_idx_t rs1_idx,
  output reg_idx_t rs2_idx,
  output id_ex_t   id_ex
);

  word_t   instr;
  opcode_e opcode;
  ctrl_t   ctrl;
  word_t   imm;
  word_t   rs1_data;
  word_t   rs2_data;
  word_t   a7_value;
  logic    is_ecall;
  logic    use_rs1;
  logic    use_rs2;

  function automatic alu_op_e alu_decode(logic [2:0] funct3, logic alt, logic reg_op);
    case (alu_funct3_e'(funct3))
      f3_add_sub: return (reg_op && alt) ? alu_sub : alu_add; // no subi
      f3_sll:     return alu_sll;
      f3_slt:     return alu_slt;
      f3_xor:     return alu_xor;
      f3_srl_sra: return alt ? alu_sra : alu_srl;
      f3_or:      return alu_or;
      f3_and:     return alu_and;
      default:    return alu_add;
    endcase
  endfunction

  assign instr    = if_id.instr;
  assign opcode   = opcode_e'(instr[6:0]);
  assign is_ecall = if_id.valid && opcode == opc_system;
  assign use_rs1  = if_id.valid &&
                    opcode inside {opc_op, opc_op_imm, opc_load, opc_store, opc_branch, opc_jalr};
  assign use_rs2  = if_id.valid && opcode inside {opc_op, opc_store, opc_branch};

  // unused ports read x0 so they never forward or stall
  // ecall reads a7 on both ports, hazard unit keys on that
  assign rs1_idx = is_ecall ? reg_a7 : use_rs1 ? instr[19:15] : '0;
  assign rs2_idx = is_ecall ? reg_a7 : use_rs2 ? instr[24:20] : '0;

  reg_file u_reg_file (
    .clk, .reset, .rs1_idx, .rs2_idx, .wb, .rs1_data, .rs2_data
  );

  assign a7_value = fwd_mux(ecall_fwd, rs1_data, mem_fwd_value, wb.data);

  always_comb begin
    case (opcode)
      opc_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      opc_branch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      opc_lui:    imm = {instr[31:12], 12'b0};
      opc_jal:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:    imm = {{20{instr[31]}}, instr[31:20]}; // I-type
    endcase
  end

  always_comb begin
    ctrl         = '0;
    ctrl.br_cond = br_cond_e'(instr[14:12]);
    ctrl.halt    = is_ecall && a7_value == word_t'(`HALT_CODE);
    if (if_id.valid) begin
      case (opcode)
        opc_op: begin
          ctrl.alu_op    = alu_decode(instr[14:12], instr[30], 1'b1);
          ctrl.reg_write = 1'b1;
        end
        opc_op_imm: begin
          ctrl.alu_op      = alu_decode(instr[14:12], instr[30], 1'b0);
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_write   = 1'b1;
        end
        opc_lui: begin
          ctrl.alu_op      = alu_pass_b;
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_write   = 1'b1;
        end
        opc_load: begin
          ctrl.alu_src_imm = 1'b1; // address = rs1 + imm
          ctrl.mem_read    = 1'b1;
          ctrl.reg_write   = 1'b1;
        end
        opc_store: begin
          ctrl.alu_src_imm = 1'b1;
          ctrl.mem_write   = 1'b1;
        end
        opc_branch: ctrl.is_branch = 1'b1;
        opc_jal: begin
          ctrl.is_jal    = 1'b1;
          ctrl.link      = 1'b1;
          ctrl.reg_write = 1'b1;
        end
        opc_jalr: begin
          ctrl.is_jalr     = 1'b1;
          ctrl.alu_src_imm = 1'b1;
          ctrl.link        = 1'b1;
          ctrl.reg_write   = 1'b1;
        end
        default: ; // system handled by halt above
      endcase
    end
  end

  always_ff @(posedge clk) begin
    id_ex.pc       <= if_id.pc;
    id_ex.rs1_data <= rs1_data;
    id_ex.rs2_data <= rs2_data;
    id_ex.imm      <= imm;
    id_ex.rs1      <= rs1_idx;
    id_ex.rs2      <= rs2_idx;
    id_ex.rd       <= instr[11:7];
    if (reset || stall || flush) begin
      id_ex.valid <= 1'b0; // bubble
      id_ex.ctrl  <= '0;
    end else begin
      id_ex.valid <= if_id.valid;
      id_ex.ctrl  <= ctrl;
    end
  end

endmodule

// File: decode/reg_file.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module reg_file import isa_pkg::*, pipe_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  input  commit_t  wb,       // write port, valid never set for x0
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [`NUM_REGS];

  // x0 reads as zero and a write in the same cycle shows through
  function automatic word_t read_port(reg_idx_t idx, commit_t w, word_t stored);
    if (idx == '0) begin
      return '0;
    end else if (w.valid && w.rd == idx) begin
      return w.data;
    end
    return stored;
  endfunction

  assign rs1_data = read_port(rs1_idx, wb, regs[rs1_idx]);
  assign rs2_data = read_port(rs2_idx, wb, regs[rs2_idx]);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid) begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule

// File: test/core_properties.sv
`timescale 1ns/1ns

module core_properties import isa_pkg::*, pipe_pkg::*; (
  input logic     clk,
  input logic     reset,
  input word_t    imem_addr,
  input mem_req_t dmem_req,
  input commit_t  commit,
  input logic     halted
);

  int failures = 0; // assertion failures so far

  // outputs quiet in the cycle after a reset edge
  quiet_after_reset: assert property (@(posedge clk)
    reset |=> !halted && !dmem_req.read && !dmem_req.write && !commit.valid)
    else begin
      failures++;
      $error("halted, a memory strobe or commit.valid high right after reset");
    end

  pc_word_aligned: assert property (@(posedge clk) disable iff (reset)
    imem_addr[1:0] == 2'b00)
    else begin
      failures++;
      $error("instruction address not word aligned");
    end

  // one data access per cycle
  strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(dmem_req.read && dmem_req.write))
    else begin
      failures++;
      $error("data memory read and write high together");
    end

  no_x0_commit: assert property (@(posedge clk) disable iff (reset)
    commit.valid |-> commit.rd != '0)
    else begin
      failures++;
      $error("commit port reported a write to x0");
    end

endmodule

bind rv_core core_properties u_props (
  .clk, .reset, .imem_addr, .dmem_req, .commit, .halted
);

// File: test/core_tb.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module core_tb import isa_pkg::*, pipe_pkg::*;;

  localparam int imem_words   = 64;
  localparam int dmem_words   = 16;
  localparam int drain_cycles = 6;   // watch for stray commits after halt

  localparam logic [6:0] op_imm  = 7'b0010011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam word_t nop         = 32'h0000_0013; // addi x0, x0, 0
  localparam word_t instr_ecall = 32'h0000_0073;

  logic     clk;
  logic     reset;
  word_t    imem_addr;
  word_t    imem_data;
  mem_req_t dmem_req;
  word_t    dmem_rdata;
  commit_t  commit;
  logic     halted;

  word_t    prog [imem_words];
  word_t    dmem [dmem_words];
  reg_idx_t exp_rd [64];      // expected commits, program order
  word_t    exp_data [64];
  reg_idx_t exp_rd_now;
  word_t    exp_data_now;
  int       prog_fill;
  int       exp_count;
  int       exp_idx;          // next table entry
  int       mismatches;
  int       other_errors;
  int       cycles;
  int       timeout_cycles;

  rv_core u_rv_core (
    .clk, .reset, .imem_addr, .imem_data, .dmem_req, .dmem_rdata, .commit, .halted
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  // instruction fetch answers in the same cycle, nop outside the program
  assign imem_data  = (imem_addr[31:8] == '0) ? prog[imem_addr[7:2]] : nop;
  assign dmem_rdata = dmem_req.read ? dmem[dmem_req.addr[5:2]] : '0;

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < dmem_words; i++) begin
        dmem[i[3:0]] <= 32'hc0de_0000 | i; // word index in the low bits
      end
    end else if (dmem_req.write) begin
      dmem[dmem_req.addr[5:2]] <= dmem_req.wdata;
    end
  end

  // RV32I instruction formats
  function automatic word_t r_format(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t i_format(int imm, int rs1, int f3, int rd, logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic word_t s_format(int imm, int rs2, int rs1); // sw only
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_format(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t u_format(int imm, int rd); // lui
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic word_t j_format(int imm, int rd); // jal
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic add_instr(word_t w);
    prog[prog_fill[5:0]] = w;
    prog_fill++;
  endtask

  task automatic push_expect(int rd, word_t data);
    exp_rd[exp_count[5:0]]   = rd[4:0];
    exp_data[exp_count[5:0]] = data;
    exp_count++;
  endtask

  task automatic build_program();
    for (int i = 0; i < imem_words; i++) begin
      prog[i[5:0]] = nop;
    end
    prog_fill = 0;
    add_instr(i_format(5, 0, 0, 1, op_imm));      // addi x1, x0, 5
    add_instr(i_format(7, 1, 0, 2, op_imm));      // addi x2, x1, 7   x1 from mem
    add_instr(r_format(0, 2, 1, 0, 3));           // add  x3, x1, x2  mem and wb
    add_instr(r_format(32, 1, 3, 0, 4));          // sub  x4, x3, x1
    add_instr(r_format(0, 1, 4, 6, 5));           // or   x5, x4, x1
    add_instr(r_format(0, 3, 5, 7, 6));           // and  x6, x5, x3
    add_instr(i_format(4, 1, 1, 7, op_imm));      // slli x7, x1, 4
    add_instr(i_format(-16, 0, 0, 8, op_imm));    // addi x8, x0, -16
    add_instr(i_format('h402, 8, 5, 9, op_imm));  // srai x9, x8, 2
    add_instr(i_format(28, 8, 5, 10, op_imm));    // srli x10, x8, 28
    add_instr(r_format(0, 1, 8, 2, 11));          // slt  x11, x8, x1
    add_instr(u_format('h12345, 12));             // lui  x12, 0x12345
    add_instr(i_format('h678, 12, 4, 13, op_imm)); // xori x13, x12, 0x678
    add_instr(r_format(0, 6, 1, 1, 14));          // sll  x14, x1, x6
    add_instr(r_format(32, 1, 8, 5, 15));         // sra  x15, x8, x1
    add_instr(r_format(0, 1, 8, 5, 16));          // srl  x16, x8, x1
    add_instr(s_format(8, 13, 0));                // sw   x13, 8(x0)
    add_instr(i_format(8, 0, 2, 18, op_load));    // lw   x18, 8(x0)
    add_instr(r_format(0, 1, 18, 0, 19));         // add  x19, x18, x1  load-use on rs1
    add_instr(i_format(4, 0, 2, 20, op_load));    // lw   x20, 4(x0)   preset word
    add_instr(r_format(32, 20, 1, 0, 21));        // sub  x21, x1, x20  load-use on rs2
    add_instr(i_format(99, 1, 0, 0, op_imm));     // addi x0, x1, 99   dropped
    add_instr(r_format(0, 1, 0, 0, 22));          // add  x22, x0, x1
    add_instr(b_format(12, 1, 1, 0));             // beq  x1, x1, +12  taken
    add_instr(i_format(1, 0, 0, 23, op_imm));     // squashed
    add_instr(i_format(2, 0, 0, 23, op_imm));     // squashed
    add_instr(b_format(8, 1, 1, 1));              // bne  x1, x1, +8   not taken
    add_instr(i_format(3, 0, 0, 23, op_imm));     // addi x23, x0, 3
    add_instr(b_format(8, 1, 8, 4));              // blt  x8, x1, +8   taken
    add_instr(i_format(1, 0, 0, 24, op_imm));     // squashed
    add_instr(b_format(8, 1, 8, 5));              // bge  x8, x1, +8   not taken
    add_instr(i_format(4, 0, 0, 24, op_imm));     // addi x24, x0, 4
    add_instr(b_format(12, 8, 1, 5));             // bge  x1, x8, +12  taken
    add_instr(i_format(1, 0, 0, 25, op_imm));     // squashed
    add_instr(i_format(2, 0, 0, 25, op_imm));     // squashed
    add_instr(b_format(8, 8, 1, 4));              // blt  x1, x8, +8   not taken
    add_instr(i_format(5, 0, 0, 25, op_imm));     // addi x25, x0, 5
    add_instr(j_format(12, 26));                  // jal  x26, +12
    add_instr(i_format(1, 0, 0, 27, op_imm));     // squashed
    add_instr(i_format(2, 0, 0, 27, op_imm));     // squashed
    add_instr(i_format(25, 26, 0, 27, op_imm));   // addi x27, x26, 25  odd target
    add_instr(i_format(0, 27, 0, 28, op_jalr));   // jalr x28, 0(x27)  bit 0 cleared
    add_instr(i_format(1, 0, 0, 29, op_imm));     // squashed
    add_instr(i_format(2, 0, 0, 29, op_imm));     // squashed
    add_instr(i_format(1, 28, 0, 29, op_imm));    // addi x29, x28, 1
    add_instr(i_format(`HALT_CODE, 0, 0, 17, op_imm)); // addi x17, x0, halt code
    add_instr(instr_ecall);
    add_instr(i_format(1, 0, 0, 30, op_imm));     // past the halt, never commits
    add_instr(i_format(2, 0, 0, 31, op_imm));
  endtask

  // worked out by hand from the program above
  task automatic fill_expected();
    exp_count = 0;
    push_expect(1, 32'h0000_0005);
    push_expect(2, 32'h0000_000c);
    push_expect(3, 32'h0000_0011);
    push_expect(4, 32'h0000_000c);
    push_expect(5, 32'h0000_000d);
    push_expect(6, 32'h0000_0001);
    push_expect(7, 32'h0000_0050);
    push_expect(8, 32'hffff_fff0);
    push_expect(9, 32'hffff_fffc);
    push_expect(10, 32'h0000_000f);
    push_expect(11, 32'h0000_0001);
    push_expect(12, 32'h1234_5000);
    push_expect(13, 32'h1234_5678);
    push_expect(14, 32'h0000_000a);
    push_expect(15, 32'hffff_ffff);
    push_expect(16, 32'h07ff_ffff);
    push_expect(18, 32'h1234_5678); // sw/lw round trip
    push_expect(19, 32'h1234_567d);
    push_expect(20, 32'hc0de_0001); // preset data word 1
    push_expect(21, 32'h3f22_0004);
    push_expect(22, 32'h0000_0005); // x0 still zero
    push_expect(23, 32'h0000_0003);
    push_expect(24, 32'h0000_0004);
    push_expect(25, 32'h0000_0005);
    push_expect(26, 32'h0000_0098); // link of jal at 0x94
    push_expect(27, 32'h0000_00b1);
    push_expect(28, 32'h0000_00a8); // link of jalr at 0xa4
    push_expect(29, 32'h0000_00a9);
    push_expect(17, `HALT_CODE);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      exp_idx <= 0;
    end else if (commit.valid) begin
      exp_idx <= exp_idx + 1;
    end
  end

  assign exp_rd_now   = exp_rd[exp_idx[5:0]];
  assign exp_data_now = exp_data[exp_idx[5:0]];

  commit_in_table: assert property (@(posedge clk) disable iff (reset)
    commit.valid |-> exp_idx < exp_count)
    else begin
      other_errors++;
      $display("commit to x%0d arrived after all %0d expected commits",
               $sampled(commit.rd), exp_count);
    end

  commit_rd_check: assert property (@(posedge clk) disable iff (reset)
    commit.valid && exp_idx < exp_count |-> commit.rd == exp_rd_now)
    else begin
      mismatches++;
      $display("mismatch commit.rd: got %h expected %h",
               $sampled(commit.rd), $sampled(exp_rd_now));
    end

  commit_data_check: assert property (@(posedge clk) disable iff (reset)
    commit.valid && exp_idx < exp_count |-> commit.data == exp_data_now)
    else begin
      mismatches++;
      $display("mismatch commit.data: got %h expected %h",
               $sampled(commit.data), $sampled(exp_data_now));
    end

  // halt only once every earlier instruction has committed
  commits_before_halt: assert property (@(posedge clk) disable iff (reset)
    $rose(halted) |-> exp_idx == exp_count)
    else begin
      other_errors++;
      $display("core halted after only %0d of %0d expected commits",
               $sampled(exp_idx), exp_count);
    end

  quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
    halted |-> !commit.valid)
    else begin
      other_errors++;
      $display("an instruction committed after the core halted");
    end

  initial begin
    reset        = 1'b1;
    mismatches   = 0;
    other_errors = 0;
    cycles       = 0;
    build_program();
    fill_expected();
    timeout_cycles = 8 * prog_fill + 20;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    while (!halted && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      other_errors++;
      $display("core never halted within %0d cycles", timeout_cycles);
    end
    repeat (drain_cycles) @(posedge clk);
    $display("errors: %0d mismatches, %0d other, %0d property failures",
             mismatches, other_errors, u_rv_core.u_props.failures);
    if (mismatches + other_errors + u_rv_core.u_props.failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module execute_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  id_ex_t   id_ex,
  input  fwd_sel_e fwd_rs1,
  input  fwd_sel_e fwd_rs2,
  input  commit_t  wb,
  output ex_mem_t  ex_mem,
  output logic     redirect,
  output word_t    redirect_pc
);

  localparam int shamt_w = $clog2(`XLEN);

  word_t op_a;
  word_t op_b_reg;   // forwarded rs2, doubles as store data
  word_t op_b;
  word_t alu_out;
  word_t pc_plus_4;
  logic  cond;
  logic  [shamt_w-1:0] shamt;

  // ex_mem holds the next older instruction, commit the one after
  assign op_a     = fwd_mux(fwd_rs1, id_ex.rs1_data, ex_mem.wb_value, wb.data);
  assign op_b_reg = fwd_mux(fwd_rs2, id_ex.rs2_data, ex_mem.wb_value, wb.data);
  assign op_b     = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b_reg;
  assign shamt    = op_b[shamt_w-1:0];

  always_comb begin
    case (id_ex.ctrl.alu_op)
      alu_add:    alu_out = op_a + op_b;
      alu_sub:    alu_out = op_a - op_b;
      alu_and:    alu_out = op_a & op_b;
      alu_or:     alu_out = op_a | op_b;
      alu_xor:    alu_out = op_a ^ op_b;
      alu_slt:    alu_out = word_t'($signed(op_a) < $signed(op_b));
      alu_sll:    alu_out = op_a << shamt;
      alu_srl:    alu_out = op_a >> shamt;
      alu_sra:    alu_out = word_t'($signed(op_a) >>> shamt);
      alu_pass_b: alu_out = op_b; // lui
      default:    alu_out = op_a + op_b;
    endcase
  end

  // branch compare always on the two register operands
  always_comb begin
    case (id_ex.ctrl.br_cond)
      br_eq:   cond = op_a == op_b_reg;
      br_ne:   cond = op_a != op_b_reg;
      br_lt:   cond = $signed(op_a) < $signed(op_b_reg);
      br_ge:   cond = $signed(op_a) >= $signed(op_b_reg);
      default: cond = 1'b0;
    endcase
  end

  assign redirect = id_ex.valid &&
                    (id_ex.ctrl.is_jal || id_ex.ctrl.is_jalr || (id_ex.ctrl.is_branch && cond));
  assign redirect_pc = id_ex.ctrl.is_jalr ? {alu_out[`XLEN-1:1], 1'b0} : id_ex.pc + id_ex.imm;
  assign pc_plus_4   = id_ex.pc + word_t'(4);

  always_ff @(posedge clk) begin
    ex_mem.alu_out    <= alu_out;
    ex_mem.store_data <= op_b_reg;
    ex_mem.rd         <= id_ex.rd;
    ex_mem.wb_value   <= id_ex.ctrl.link ? pc_plus_4 : alu_out;
    if (reset) begin
      ex_mem.valid     <= 1'b0;
      ex_mem.mem_read  <= 1'b0;
      ex_mem.mem_write <= 1'b0;
      ex_mem.reg_write <= 1'b0;
      ex_mem.halt      <= 1'b0;
    end else begin
      ex_mem.valid     <= id_ex.valid;
      ex_mem.mem_read  <= id_ex.valid && id_ex.ctrl.mem_read;
      ex_mem.mem_write <= id_ex.valid && id_ex.ctrl.mem_write;
      ex_mem.reg_write <= id_ex.valid && id_ex.ctrl.reg_write;
      ex_mem.halt      <= id_ex.valid && id_ex.ctrl.halt;
    end
  end

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module fetch_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   stall,        // load-use hold
  input  logic   redirect,     // taken branch or jump resolved in execute
  input  word_t  redirect_pc,
  output word_t  imem_addr,
  input  word_t  imem_data,    // comes back in the same cycle
  output if_id_t if_id
);

  word_t pc;
  word_t pc_next;

  assign imem_addr = pc;

  // static not-taken, redirect beats stall
  assign pc_next = redirect ? redirect_pc :
                   stall    ? pc          :
                              pc + word_t'(4);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || redirect) begin
      if_id.valid <= 1'b0; // wrong-path fetch dropped
    end else if (!stall) begin
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.instr <= imem_data;
    end
  end

endmodule

// File: verilog/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit import isa_pkg::*, pipe_pkg::*; (
  input  reg_idx_t rs1_idx,    // decode reads
  input  reg_idx_t rs2_idx,
  input  id_ex_t   id_ex,
  input  ex_mem_t  ex_mem,
  input  commit_t  wb,
  output logic     stall,
  output fwd_sel_e ecall_fwd,
  output fwd_sel_e fwd_rs1,
  output fwd_sel_e fwd_rs2
);

  logic ecall_read;
  logic load_use;
  logic a7_pending;

  // youngest producer first, x0 never forwarded
  function automatic fwd_sel_e pick(reg_idx_t idx, ex_mem_t em, commit_t cm);
    if (idx == '0) begin
      return fwd_none;
    end else if (em.valid && em.reg_write && em.rd == idx) begin
      return fwd_from_mem;
    end else if (cm.valid && cm.rd == idx) begin
      return fwd_from_wb;
    end
    return fwd_none;
  endfunction

  assign fwd_rs1   = pick(id_ex.rs1, ex_mem, wb);
  assign fwd_rs2   = pick(id_ex.rs2, ex_mem, wb);
  assign ecall_fwd = pick(rs1_idx, ex_mem, wb);

  // load result only exists after MEM, one bubble lets it reach WB
  assign load_use = id_ex.valid && id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                    (id_ex.rd == rs1_idx || id_ex.rd == rs2_idx);

  // decode drives a7 on both ports for ecall
  assign ecall_read = rs1_idx == reg_a7 && rs2_idx == reg_a7;
  // halt check needs a7 now, so wait while it is still in execute or a load in MEM
  assign a7_pending = ecall_read &&
                      ((id_ex.valid && id_ex.ctrl.reg_write && id_ex.rd == reg_a7) ||
                       (ex_mem.valid && ex_mem.mem_read && ex_mem.rd == reg_a7));

  assign stall = load_use || a7_pending;

endmodule

// File: verilog/memory_stage.sv
`timescale 1ns/1ns

module memory_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  ex_mem_t  ex_mem,
  output mem_req_t dmem_req,
  input  word_t    dmem_rdata,  // combinational read
  output commit_t  wb,
  output logic     halted
);

  logic live;

  // nothing younger than the ecall touches memory or registers
  assign live = ex_mem.valid && !halted;

  assign dmem_req.read  = live && ex_mem.mem_read;
  assign dmem_req.write = live && ex_mem.mem_write;
  assign dmem_req.addr  = ex_mem.alu_out;
  assign dmem_req.wdata = ex_mem.store_data;

  always_ff @(posedge clk) begin
    wb.rd   <= ex_mem.rd;
    wb.data <= ex_mem.mem_read ? dmem_rdata : ex_mem.wb_value;
    if (reset) begin
      wb.valid <= 1'b0;
      halted   <= 1'b0;
    end else begin
      wb.valid <= live && ex_mem.reg_write && ex_mem.rd != '0; // x0 writes dropped
      if (live && ex_mem.halt) begin
        halted <= 1'b1; // sticky until reset
      end
    end
  end

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ns

module rv_core import isa_pkg::*, pipe_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  output word_t    imem_addr,
  input  word_t    imem_data,
  output mem_req_t dmem_req,
  input  word_t    dmem_rdata,
  output commit_t  commit,     // MEM/WB result, also the register write port
  output logic     halted
);

  if_id_t   if_id;
  id_ex_t   id_ex;
  ex_mem_t  ex_mem;
  logic     stall;
  logic     redirect;
  word_t    redirect_pc;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  fwd_sel_e ecall_fwd;
  fwd_sel_e fwd_rs1;
  fwd_sel_e fwd_rs2;

  fetch_stage u_fetch (
    .clk, .reset, .stall, .redirect, .redirect_pc,
    .imem_addr, .imem_data, .if_id
  );

  decode_stage u_decode (
    .clk, .reset, .stall,
    .flush         (redirect),          // squash the instruction behind a taken jump
    .if_id,
    .wb            (commit),
    .mem_fwd_value (ex_mem.wb_value),
    .ecall_fwd, .rs1_idx, .rs2_idx, .id_ex
  );

  execute_stage u_execute (
    .clk, .reset, .id_ex, .fwd_rs1, .fwd_rs2,
    .wb (commit),
    .ex_mem, .redirect, .redirect_pc
  );

  memory_stage u_memory (
    .clk, .reset, .ex_mem, .dmem_req, .dmem_rdata,
    .wb (commit),
    .halted
  );

  hazard_unit u_hazard (
    .rs1_idx, .rs2_idx, .id_ex, .ex_mem,
    .wb (commit),
    .stall, .ecall_fwd, .fwd_rs1, .fwd_rs2
  );

endmodule

// File: vlog.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
verilog/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/hazard_unit.sv
verilog/rv_core.sv
test/core_properties.sv
test/core_tb.sv
